// File: hw/dz_pkg.sv
package dz_pkg;

    localparam int NUM_ROWS = 8;
    localparam int GLYPH_W = 4;

    // scan rate, small for simulation
    localparam int ROW_DIV = 16;

    // animation pacing
    localparam int FRAMES_PER_STEP = 3;
    localparam logic [GLYPH_W-1:0] ANIM_LAST = 4'd4;

    // colour class of a glyph
    typedef enum logic [1:0]
    {
        HUE_GREEN,  // red plane dark
        HUE_AMBER,  // red follows green
        HUE_WARM,   // red follows green only while temp is set
        HUE_OFF     // blank
    } hue_t;

    // column words, row 0 first, bit set = lit
    localparam logic [NUM_ROWS-1:0] glyph_bitmap [16][NUM_ROWS] = '{
        // 0..4 grow from a small blob to a full disc
        '{8'b0000_0000, 8'b0000_0000, 8'b0001_1000, 8'b0011_1100,
          8'b0011_1100, 8'b0001_1000, 8'b0000_0000, 8'b0000_0000},
        '{8'b0000_0000, 8'b0000_0000, 8'b0011_1000, 8'b0111_1100,
          8'b0111_1100, 8'b0011_1000, 8'b0000_0000, 8'b0000_0000},
        '{8'b0000_0000, 8'b0000_0000, 8'b0011_1100, 8'b0111_1110,
          8'b0111_1110, 8'b0011_1100, 8'b0000_0000, 8'b0000_0000},
        '{8'b0000_0000, 8'b0011_1100, 8'b0111_1110, 8'b0111_1110,
          8'b0111_1110, 8'b0111_1110, 8'b0011_1100, 8'b0000_0000},
        '{8'b0011_1100, 8'b0111_1110, 8'b1111_1111, 8'b1111_1111,
          8'b1111_1111, 8'b1111_1111, 8'b0111_1110, 8'b0011_1100},
        // 5 full panel
        '{8'b1111_1111, 8'b1111_1111, 8'b1111_1111, 8'b1111_1111,
          8'b1111_1111, 8'b1111_1111, 8'b1111_1111, 8'b1111_1111},
        '{8'b1100_0011, 8'b1110_0011, 8'b1111_0001, 8'b1110_0011,
          8'b1100_0111, 8'b1110_0111, 8'b1111_0111, 8'b1111_1011},
        '{8'b0000_0000, 8'b0000_0001, 8'b1000_0001, 8'b1100_0011,
          8'b1000_0011, 8'b1100_0111, 8'b1110_0111, 8'b1111_0011},
        '{8'b0000_0000, 8'b0011_1000, 8'b0100_0100, 8'b0101_1010,
          8'b0100_1010, 8'b0011_0010, 8'b1100_0100, 8'b0011_1000},
        '{8'b0000_0000, 8'b0000_0000, 8'b0110_0000, 8'b1111_1100,
          8'b0011_1111, 8'b0011_1110, 8'b0001_1100, 8'b0000_0000},
        '{8'b0000_0000, 8'b0000_0000, 8'b0001_1000, 8'b0011_1100,
          8'b0111_1110, 8'b0111_1110, 8'b0010_0100, 8'b0000_0000},
        '{8'b1110_0000, 8'b0110_0000, 8'b1110_0000, 8'b0011_0000,
          8'b0011_0001, 8'b0011_0011, 8'b0011_1110, 8'b0001_1100},
        // 12..15 unused, blank
        '{8'b0000_0000, 8'b0000_0000, 8'b0000_0000, 8'b0000_0000,
          8'b0000_0000, 8'b0000_0000, 8'b0000_0000, 8'b0000_0000},
        '{8'b0000_0000, 8'b0000_0000, 8'b0000_0000, 8'b0000_0000,
          8'b0000_0000, 8'b0000_0000, 8'b0000_0000, 8'b0000_0000},
        '{8'b0000_0000, 8'b0000_0000, 8'b0000_0000, 8'b0000_0000,
          8'b0000_0000, 8'b0000_0000, 8'b0000_0000, 8'b0000_0000},
        '{8'b0000_0000, 8'b0000_0000, 8'b0000_0000, 8'b0000_0000,
          8'b0000_0000, 8'b0000_0000, 8'b0000_0000, 8'b0000_0000}
    };

    // hue class per glyph
    localparam hue_t glyph_hue [16] = '{
        HUE_WARM,   // 0
        HUE_WARM,
        HUE_WARM,
        HUE_WARM,
        HUE_WARM,
        HUE_WARM,   // 5
        HUE_AMBER,
        HUE_AMBER,
        HUE_AMBER,
        HUE_AMBER,
        HUE_GREEN,  // 10
        HUE_AMBER,
        HUE_OFF,
        HUE_OFF,
        HUE_OFF,
        HUE_OFF
    };

endpackage

// File: hw/dz_show.sv
`timescale 1ns/10ps

module dz_show
    import dz_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                st,
    input  logic                temp,
    input  logic                row_step,
    input  logic [GLYPH_W-1:0]  glyph,
    output logic [NUM_ROWS-1:0] row,
    output logic [NUM_ROWS-1:0] colg,
    output logic [NUM_ROWS-1:0] colr,
    output logic                frame_done
);

    logic [$clog2(NUM_ROWS)-1:0] row_idx;
    logic [GLYPH_W-1:0]          glyph_q;

    hue_t                        hue;
    logic                        red_on;
    logic [NUM_ROWS-1:0]         green_w;
    logic [NUM_ROWS-1:0]         red_w;
    logic [NUM_ROWS-1:0]         row_sel;

    // last row being left behind
    assign frame_done = row_step && (row_idx == NUM_ROWS - 1);

    // row scan and glyph latch
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row_idx <= '0;
            glyph_q <= '0;
        end
        else if (!st)
        begin
            row_idx <= '0;
            glyph_q <= '0;
        end
        else if (row_step)
        begin
            if (frame_done)
            begin
                row_idx <= '0;
                glyph_q <= glyph;  // new glyph only at the top
            end
            else
            begin
                row_idx <= row_idx + 1'b1;
            end
        end
    end

    always_comb
    begin
        hue = glyph_hue[glyph_q];

        if (hue == HUE_OFF)
            green_w = '0;
        else
            green_w = glyph_bitmap[glyph_q][row_idx];

        // amber = both planes lit
        red_on = (hue == HUE_AMBER) || ((hue == HUE_WARM) && temp);
        red_w  = red_on ? green_w : '0;

        row_sel = {{(NUM_ROWS-1){1'b0}}, 1'b1} << row_idx;
    end

    // output registers one cycle behind row_idx/glyph_q
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row  <= '1;
            colg <= '0;
            colr <= '0;
        end
        else if (!st)
        begin
            row  <= '1;  // blank
            colg <= '0;
            colr <= '0;
        end
        else
        begin
            row  <= ~row_sel;  // active low
            colg <= green_w;
            colr <= red_w;
        end
    end

    a_row_one_low: assert property (
        @(posedge clk) disable iff (rst)
        (row == '1) || $onehot(~row)
    );

    // a scanned row is held until the next strobe
    a_row_hold: assert property (
        @(posedge clk) disable iff (rst)
        (st && $past(st) && !$past(row_step, 2) && $past(row) != '1) |-> $stable(row)
    );

endmodule

// File: hw/dz_top.sv
`timescale 1ns/10ps

module dz_top
    import dz_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                st,
    input  logic                anim,
    input  logic                temp,
    input  logic [GLYPH_W-1:0]  num,
    output logic [NUM_ROWS-1:0] row,
    output logic [NUM_ROWS-1:0] colg,
    output logic [NUM_ROWS-1:0] colr
);

    logic               row_step;
    logic               frame_done;
    logic [GLYPH_W-1:0] glyph;

    row_timer u_timer (
        .clk      (clk),
        .rst      (rst),
        .st       (st),
        .row_step (row_step)
    );

    glyph_seq u_seq (
        .clk        (clk),
        .rst        (rst),
        .st         (st),
        .anim       (anim),
        .frame_done (frame_done),
        .num        (num),
        .glyph      (glyph)
    );

    dz_show u_show (
        .clk        (clk),
        .rst        (rst),
        .st         (st),
        .temp       (temp),
        .row_step   (row_step),
        .glyph      (glyph),
        .row        (row),
        .colg       (colg),
        .colr       (colr),
        .frame_done (frame_done)
    );

endmodule

// File: hw/glyph_seq.sv
`timescale 1ns/10ps

module glyph_seq
    import dz_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               st,
    input  logic               anim,
    input  logic               frame_done,
    input  logic [GLYPH_W-1:0] num,
    output logic [GLYPH_W-1:0] glyph
);

    logic [$clog2(FRAMES_PER_STEP)-1:0] frame_cnt;
    logic [GLYPH_W-1:0]                 step;
    logic [GLYPH_W-1:0]                 num_q;
    logic                               step_due;

    // last frame of the current animation glyph
    assign step_due = frame_done && (frame_cnt == FRAMES_PER_STEP - 1);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            frame_cnt <= '0;
            step      <= '0;
        end
        else if (!st || !anim)
        begin
            // restart from glyph 0 next time
            frame_cnt <= '0;
            step      <= '0;
        end
        else if (step_due)
        begin
            frame_cnt <= '0;
            if (step == ANIM_LAST)
                step <= '0;
            else
                step <= step + 1'b1;
        end
        else if (frame_done)
        begin
            frame_cnt <= frame_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            num_q <= '0;
        else
            num_q <= num;  // static path
    end

    // dz_show only samples this at the wrap
    assign glyph = anim ? step : num_q;

    a_anim_range: assert property (
        @(posedge clk) disable iff (rst)
        anim |-> (glyph <= ANIM_LAST)
    );

endmodule

// File: hw/row_timer.sv
`timescale 1ns/10ps

module row_timer
    import dz_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic st,
    output logic row_step
);

    logic [$clog2(ROW_DIV)-1:0] cnt;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            cnt <= '0;
        else if (!st)
            cnt <= '0;  // held idle while disabled
        else if (cnt == ROW_DIV - 1)
            cnt <= '0;
        else
            cnt <= cnt + 1'b1;
    end

    assign row_step = st && (cnt == ROW_DIV - 1);

    // strobe spacing
    a_step_single: assert property (
        @(posedge clk) disable iff (rst)
        row_step |=> !row_step
    );

endmodule

// File: tests/dz_tb.sv
`timescale 1ns/10ps

module dz_tb
    import dz_pkg::*;
;

    localparam int FRAME_CYC   = NUM_ROWS * ROW_DIV;
    localparam int TIMEOUT_CYC = 60 * FRAME_CYC * 11 / 10;
    localparam int STATIC_SEGS = 10;
    localparam int ANIM_FRAMES = 20;

    logic                clk;
    logic                rst;
    logic                st;
    logic                anim;
    logic                temp;
    logic [GLYPH_W-1:0]  num;
    logic [NUM_ROWS-1:0] row;
    logic [NUM_ROWS-1:0] colg;
    logic [NUM_ROWS-1:0] colr;

    integer              seed;
    int                  cyc;
    logic [NUM_ROWS-1:0] prev_row;
    int                  hold_cnt;
    logic                first_row;
    logic                frame_valid;
    logic                frame_end;
    logic [GLYPH_W-1:0]  num_hist [4];
    logic                exp_known;
    logic [GLYPH_W-1:0]  exp_glyph;

    // one captured frame indexed by row
    logic [NUM_ROWS-1:0] cap_g [NUM_ROWS];
    logic [NUM_ROWS-1:0] cap_r [NUM_ROWS];
    logic                cap_t [NUM_ROWS];

    int                  static_frames;
    int                  anim_frames;
    int                  anim_steps;
    int                  anim_run;
    logic [GLYPH_W-1:0]  anim_cur;
    logic                anim_first;

    dz_top uut (
        .clk  (clk),
        .rst  (rst),
        .st   (st),
        .anim (anim),
        .temp (temp),
        .num  (num),
        .row  (row),
        .colg (colg),
        .colr (colr)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    function automatic logic [NUM_ROWS-1:0] green_of(input logic [GLYPH_W-1:0] g, input int r);
        if (glyph_hue[g] == HUE_OFF)
            return '0;
        return glyph_bitmap[g][r];
    endfunction

    // amber where both planes light
    function automatic logic [NUM_ROWS-1:0] red_of(input logic [GLYPH_W-1:0] g, input int r,
                                                   input logic t);
        logic [NUM_ROWS-1:0] gw;
        gw = green_of(g, r);
        if (glyph_hue[g] == HUE_AMBER)
            return gw;
        if (glyph_hue[g] == HUE_WARM && t)
            return gw;
        return '0;
    endfunction

    function automatic logic frame_matches(input logic [GLYPH_W-1:0] g);
        int r;
        for (r = 0; r < NUM_ROWS; r++)
        begin
            if (cap_g[r] != green_of(g, r) || cap_r[r] != red_of(g, r, cap_t[r]))
                return 1'b0;
        end
        return 1'b1;
    endfunction

    function automatic int row_index(input logic [NUM_ROWS-1:0] r);
        int i;
        row_index = 0;
        for (i = 0; i < NUM_ROWS; i++)
            if (!r[i])
                row_index = i;
    endfunction

    // compare a fully captured frame
    task automatic check_frame();
        int                 g;
        int                 r;
        logic               found;
        logic [GLYPH_W-1:0] hit;
        logic [GLYPH_W-1:0] nxt;
        found = 1'b0;
        hit   = '0;
        for (g = 15; g >= 0; g--)
        begin
            if (frame_matches(g))
            begin
                found = 1'b1;
                hit   = g;
            end
        end
        assert (found)
        else fail_run($sformatf("captured frame is a mix of glyphs, row 0 colg 0x%h colr 0x%h",
                                cap_g[0], cap_r[0]));
        if (anim)
        begin
            assert (hit <= ANIM_LAST)
            else fail_run($sformatf("Error: glyph 0x%h outside the animation", hit));
            nxt = (anim_cur == ANIM_LAST) ? '0 : anim_cur + 1'b1;
            if (anim_frames == 0)
            begin
                // animation restarts from glyph 0
                assert (hit == '0)
                else fail_run($sformatf("Error: glyph got 0x%h expected 0x%h", hit, 4'h0));
                anim_cur = hit;
                anim_run = 1;
            end
            else if (hit == anim_cur)
            begin
                anim_run++;
                assert (anim_run <= FRAMES_PER_STEP)
                else fail_run("animation glyph held for too many frames");
            end
            else
            begin
                assert (hit == nxt)
                else fail_run($sformatf("Error: glyph got 0x%h expected 0x%h", hit, nxt));
                assert (anim_first || anim_run == FRAMES_PER_STEP)
                else fail_run("animation glyph held for too few frames");
                anim_cur   = hit;
                anim_run   = 1;
                anim_first = 1'b0;
                anim_steps++;
            end
            anim_frames++;
        end
        else if (exp_known)
        begin
            for (r = 0; r < NUM_ROWS; r++)
            begin
                assert (cap_g[r] == green_of(exp_glyph, r))
                else fail_run($sformatf("Error: colg row %0d got 0x%h expected 0x%h",
                                        r, cap_g[r], green_of(exp_glyph, r)));
                assert (cap_r[r] == red_of(exp_glyph, r, cap_t[r]))
                else fail_run($sformatf("Error: colr row %0d got 0x%h expected 0x%h",
                                        r, cap_r[r], red_of(exp_glyph, r, cap_t[r])));
            end
            static_frames++;
        end
    endtask

    // outputs settle after the rising edge, read them on the falling one
    task automatic tick();
        int idx;
        @(negedge clk);
        cyc++;
        if (cyc > TIMEOUT_CYC)
            fail_run("timeout, the run took more cycles than allowed");
        num_hist[3] = num_hist[2];
        num_hist[2] = num_hist[1];
        num_hist[1] = num_hist[0];
        num_hist[0] = num;
        if (rst || !st)
        begin
            assert (row == '1)
            else fail_run($sformatf("Error: row got 0x%h expected 0x%h", row, 8'hff));
            assert (colg == '0)
            else fail_run($sformatf("Error: colg got 0x%h expected 0x%h", colg, 8'h00));
            assert (colr == '0)
            else fail_run($sformatf("Error: colr got 0x%h expected 0x%h", colr, 8'h00));
            frame_valid = 1'b0;
        end
        else
        begin
            assert ($onehot(~row))
            else fail_run($sformatf("Error: row 0x%h does not have exactly one low bit", row));
            if (row != prev_row)
            begin
                if (prev_row == '1)
                begin
                    assert (row == 8'hfe)
                    else fail_run($sformatf("Error: row got 0x%h expected 0x%h", row, 8'hfe));
                    first_row = 1'b1;  // length of this one not checked
                end
                else
                begin
                    assert (row == {prev_row[NUM_ROWS-2:0], prev_row[NUM_ROWS-1]})
                    else fail_run($sformatf("Error: row got 0x%h expected 0x%h", row,
                                            {prev_row[NUM_ROWS-2:0], prev_row[NUM_ROWS-1]}));
                    assert (first_row || hold_cnt == ROW_DIV)
                    else fail_run($sformatf("row held %0d cycles instead of %0d",
                                            hold_cnt, ROW_DIV));
                    first_row = 1'b0;
                    if (row == 8'hfe)
                    begin
                        if (frame_valid)
                            check_frame();
                        frame_valid = 1'b1;
                        // latched glyph came from num two cycles back
                        exp_known = (num_hist[1] == num_hist[2]) && (num_hist[2] == num_hist[3]);
                        exp_glyph = num_hist[2];
                    end
                end
                hold_cnt = 0;
                idx = row_index(row);
                cap_g[idx] = colg;
                cap_r[idx] = colr;
                cap_t[idx] = temp;
            end
        end
        hold_cnt++;
        prev_row = row;
        frame_end = (row == 8'h7f) && (hold_cnt == ROW_DIV);  // next edge wraps to row 0
    endtask

    task automatic run_cycles(input int n);
        repeat (n)
        begin
            tick();
            if (frame_end)
                temp = $random(seed);  // new temp for the whole next frame
        end
    endtask

    task automatic idle_phase();
        int n;
        n = 20 + $unsigned($random(seed)) % 30;
        st = 1'b0;
        run_cycles(n);
    endtask

    initial
    begin
        int seg;
        int hold;
        seed = 32'haf58_35e5;
        rst  = 1'b1;
        st   = 1'b0;
        anim = 1'b0;
        temp = 1'b0;
        num  = '0;
        cyc           = 0;
        prev_row      = '1;
        hold_cnt      = 0;
        first_row     = 1'b0;
        frame_valid   = 1'b0;
        frame_end     = 1'b0;
        exp_known     = 1'b0;
        exp_glyph     = '0;
        static_frames = 0;
        anim_frames   = 0;
        anim_steps    = 0;
        anim_run      = 0;
        anim_cur      = '0;
        anim_first    = 1'b1;
        for (seg = 0; seg < 4; seg++)
            num_hist[seg] = '0;

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        idle_phase();

        // static glyphs with changes anywhere in a frame
        st = 1'b1;
        for (seg = 0; seg < STATIC_SEGS; seg++)
        begin
            num  = $random(seed);
            hold = 2 * FRAME_CYC + $unsigned($random(seed)) % FRAME_CYC;
            run_cycles(hold);
        end
        idle_phase();

        anim = 1'b1;
        st   = 1'b1;
        while (anim_frames < ANIM_FRAMES)
        begin
            run_cycles(1);
            if (($random(seed) & 63) == 0)
                num = $random(seed);  // ignored while animating
        end
        idle_phase();

        assert (static_frames >= STATIC_SEGS / 2)
        else fail_run("too few static frames were compared");
        if (anim_steps >= ANIM_LAST + 1)
            $display("Simulation passed");
        else
            fail_run("animation did not step through its glyphs");
        $finish;
    end

endmodule

// File: vlog.f
hw/dz_pkg.sv
hw/row_timer.sv
hw/glyph_seq.sv
hw/dz_show.sv
hw/dz_top.sv
tests/dz_tb.sv
